//--- run_sim.sh
#!/bin/sh
# build and run the pipeline testbench with Verilator
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_bp_nn -f vlog.f \
	&& ./obj_dir/Vtb_bp_nn > sim.log 2>&1 \
	|| echo "build or run stopped early"

cat sim.log 2>/dev/null

grep -q "NO ERRORS" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- src/activation_stage.sv
// stage 2, saturating linear activation
`timescale 1ns/100ps
`default_nettype none

module activation_stage
	import nn_types_pkg::*;
#(
	parameter int N_HID = 6,
	parameter int N_OUT = 2
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	input  hid_acc_t in_z [N_HID],
	input  in_t      in_desired [N_OUT],
	output logic     out_valid,
	output act_t     out_v [N_HID],
	output in_t      out_desired [N_OUT]
);

	for (genvar h = 0; h < N_HID; h++) begin : g_neuron
		hid_acc_t half;

		// slope of one half
		assign half = in_z[h] >>> 1;

		always_ff @(posedge clk) begin
			if (half > ACT_LIMIT) begin
				out_v[h] <= act_t'(ACT_LIMIT);
			end else if (half < -ACT_LIMIT) begin
				out_v[h] <= act_t'(-ACT_LIMIT);
			end else begin
				out_v[h] <= act_t'(half);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		out_desired <= in_desired;
	end

endmodule

`default_nettype wire

//--- src/bp_nn_top.sv
// two-layer inference pipeline
`timescale 1ns/100ps
`default_nettype none

module bp_nn_top
	import nn_types_pkg::*, nn_bus_pkg::*;
#(
	parameter int N_IN  = 4,
	parameter int N_HID = 6,
	parameter int N_OUT = 2
) (
	input  logic     clk,
	input  logic     reset,
	input  wb_req_t  wb_req,
	output wb_rsp_t  wb_rsp,
	input  logic     sample_valid,
	input  in_t      sample_x [N_IN],
	input  in_t      sample_desired [N_OUT],
	output logic     result_valid,
	output out_acc_t result_y [N_OUT],
	output err_t     result_err [N_OUT]
);

	weight_t  w_hid [N_HID][N_IN];
	weight_t  w_out [N_OUT][N_HID];

	// stage 1 to stage 2
	logic     s1_valid;
	hid_acc_t s1_z [N_HID];
	in_t      s1_desired [N_OUT];

	// stage 2 to stage 3
	logic     s2_valid;
	act_t     s2_v [N_HID];
	in_t      s2_desired [N_OUT];

	weight_store #(.N_IN(N_IN), .N_HID(N_HID), .N_OUT(N_OUT)) i_weight_store (
		.clk(clk), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp),
		.w_hid(w_hid), .w_out(w_out)
	);

	hidden_layer #(.N_IN(N_IN), .N_HID(N_HID), .N_OUT(N_OUT)) i_hidden_layer (
		.clk(clk), .reset(reset), .in_valid(sample_valid), .in_x(sample_x),
		.in_desired(sample_desired), .w_hid(w_hid), .out_valid(s1_valid),
		.out_z(s1_z), .out_desired(s1_desired)
	);

	activation_stage #(.N_HID(N_HID), .N_OUT(N_OUT)) i_activation_stage (
		.clk(clk), .reset(reset), .in_valid(s1_valid), .in_z(s1_z),
		.in_desired(s1_desired), .out_valid(s2_valid), .out_v(s2_v),
		.out_desired(s2_desired)
	);

	output_layer #(.N_HID(N_HID), .N_OUT(N_OUT)) i_output_layer (
		.clk(clk), .reset(reset), .in_valid(s2_valid), .in_v(s2_v),
		.in_desired(s2_desired), .w_out(w_out), .out_valid(result_valid),
		.out_y(result_y), .out_err(result_err)
	);

endmodule

`default_nettype wire

//--- src/hidden_layer.sv
// stage 1, hidden neuron dot products
`timescale 1ns/100ps
`default_nettype none

module hidden_layer
	import nn_types_pkg::*;
#(
	parameter int N_IN  = 4,
	parameter int N_HID = 6,
	parameter int N_OUT = 2
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	input  in_t      in_x [N_IN],
	input  in_t      in_desired [N_OUT],
	input  weight_t  w_hid [N_HID][N_IN],
	output logic     out_valid,
	output hid_acc_t out_z [N_HID],
	output in_t      out_desired [N_OUT]
);

	for (genvar h = 0; h < N_HID; h++) begin : g_neuron
		hid_acc_t sum;

		// products are formed at full accumulator width
		always_comb begin
			sum = '0;
			for (int i = 0; i < N_IN; i++) begin
				sum = sum + in_x[i] * w_hid[h][i];
			end
		end

		always_ff @(posedge clk) begin
			out_z[h] <= sum;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// desired values travel alongside the sample
	always_ff @(posedge clk) begin
		out_desired <= in_desired;
	end

endmodule

`default_nettype wire

//--- src/nn_bus_pkg.sv
// weight bus definitions
`default_nettype none

package nn_bus_pkg;

	localparam int WB_ADR_W = 8;
	localparam int WB_DAT_W = 16;

	// master to slave, Wishbone classic
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [WB_ADR_W-1:0] adr;
		logic [WB_DAT_W-1:0] dat;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic                ack;
		logic [WB_DAT_W-1:0] dat;
	} wb_rsp_t;

	// layer-1 weight, hidden neuron h and input i
	function automatic int l1_addr(input int h, input int i, input int n_in);
		return h * n_in + i;
	endfunction

	// layer-2 weights sit right after the layer-1 block
	function automatic int l2_addr(
		input int o,
		input int h,
		input int n_in,
		input int n_hid
	);
		return n_in * n_hid + o * n_hid + h;
	endfunction

endpackage

`default_nettype wire

//--- src/nn_types_pkg.sv
// network datapath types
`default_nettype none

package nn_types_pkg;

	// sample inputs and desired outputs, 8-bit magnitude plus sign
	localparam int IN_W = 9;
	localparam int WEIGHT_W = 8;

	// four 17-bit products need 19 bits, one spare
	localparam int HID_ACC_W = 20;

	// activation output never exceeds +-ACT_LIMIT
	localparam int ACT_W = 9;

	// six 17-bit products
	localparam int OUT_ACC_W = 20;

	// twice the output minus desired value
	localparam int ERR_W = 22;

	// activation saturation level, reached at a hidden sum of +-200
	localparam int ACT_LIMIT = 100;

	typedef logic signed [IN_W-1:0] in_t;

	typedef logic signed [WEIGHT_W-1:0] weight_t;

	typedef logic signed [HID_ACC_W-1:0] hid_acc_t;

	typedef logic signed [ACT_W-1:0] act_t;

	typedef logic signed [OUT_ACC_W-1:0] out_acc_t;

	typedef logic signed [ERR_W-1:0] err_t;

endpackage

`default_nettype wire

//--- src/output_layer.sv
// stage 3, output sums and error terms
`timescale 1ns/100ps
`default_nettype none

module output_layer
	import nn_types_pkg::*;
#(
	parameter int N_HID = 6,
	parameter int N_OUT = 2
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	input  act_t     in_v [N_HID],
	input  in_t      in_desired [N_OUT],
	input  weight_t  w_out [N_OUT][N_HID],
	output logic     out_valid,
	output out_acc_t out_y [N_OUT],
	output err_t     out_err [N_OUT]
);

	for (genvar o = 0; o < N_OUT; o++) begin : g_output
		out_acc_t sum;
		err_t     err;

		always_comb begin
			sum = '0;
			for (int h = 0; h < N_HID; h++) begin
				sum = sum + in_v[h] * w_out[o][h];
			end
		end

		// error from the same unregistered sum, so y and err stay aligned
		assign err = err_t'(sum - in_desired[o]) <<< 1;

		always_ff @(posedge clk) begin
			out_y[o]   <= sum;
			out_err[o] <= err;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

endmodule

`default_nettype wire

//--- src/weight_store.sv
// weight register file with wishbone slave
`timescale 1ns/100ps
`default_nettype none

module weight_store
	import nn_types_pkg::*, nn_bus_pkg::*;
#(
	parameter int N_IN  = 4,
	parameter int N_HID = 6,
	parameter int N_OUT = 2
) (
	input  logic    clk,
	input  logic    reset,
	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	output weight_t w_hid [N_HID][N_IN],
	output weight_t w_out [N_OUT][N_HID]
);

	logic                req;
	logic                ack_q;
	logic [WB_DAT_W-1:0] rd_dat_q;
	weight_t             rd_weight;

	// new request only while no ack is pending
	assign req = wb_req.cyc && wb_req.stb && !ack_q;

	assign wb_rsp = '{ack: ack_q, dat: rd_dat_q};

	// read mux, unmapped addresses give zero
	always_comb begin
		rd_weight = '0;
		for (int h = 0; h < N_HID; h++) begin
			for (int i = 0; i < N_IN; i++) begin
				if (int'(wb_req.adr) == l1_addr(h, i, N_IN)) begin
					rd_weight = w_hid[h][i];
				end
			end
		end
		for (int o = 0; o < N_OUT; o++) begin
			for (int h = 0; h < N_HID; h++) begin
				if (int'(wb_req.adr) == l2_addr(o, h, N_IN, N_HID)) begin
					rd_weight = w_out[o][h];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_q <= 1'b0;
			w_hid <= '{default: '0};
			w_out <= '{default: '0};
		end else begin
			ack_q <= req;
			if (req && wb_req.we) begin
				// only the low byte of the data word is kept
				for (int h = 0; h < N_HID; h++) begin
					for (int i = 0; i < N_IN; i++) begin
						if (int'(wb_req.adr) == l1_addr(h, i, N_IN)) begin
							w_hid[h][i] <= wb_req.dat[WEIGHT_W-1:0];
						end
					end
				end
				for (int o = 0; o < N_OUT; o++) begin
					for (int h = 0; h < N_HID; h++) begin
						if (int'(wb_req.adr) == l2_addr(o, h, N_IN, N_HID)) begin
							w_out[o][h] <= wb_req.dat[WEIGHT_W-1:0];
						end
					end
				end
			end
		end
	end

	// sign-extended read data, valid with ack
	always_ff @(posedge clk) begin
		if (req) begin
			rd_dat_q <= {{(WB_DAT_W - WEIGHT_W){rd_weight[WEIGHT_W-1]}}, rd_weight};
		end
	end

endmodule

`default_nettype wire

//--- include/nn_ref_model.svh
// network reference model
`ifndef NN_REF_MODEL_SVH
`define NN_REF_MODEL_SVH

// included inside the testbench module, which provides N_IN, N_HID and N_OUT

// half the sum, clamped to +-ACT_LIMIT
function automatic nn_types_pkg::act_t ref_activation(input int z);
	int half;
	half = z >>> 1;
	if (half > nn_types_pkg::ACT_LIMIT) begin
		half = nn_types_pkg::ACT_LIMIT;
	end else if (half < -nn_types_pkg::ACT_LIMIT) begin
		half = -nn_types_pkg::ACT_LIMIT;
	end
	return nn_types_pkg::act_t'(half);
endfunction

// full forward pass in plain integer arithmetic
function automatic void ref_forward(
	input  nn_types_pkg::in_t      x [N_IN],
	input  nn_types_pkg::weight_t  w_hid [N_HID][N_IN],
	input  nn_types_pkg::weight_t  w_out [N_OUT][N_HID],
	output nn_types_pkg::out_acc_t y [N_OUT]
);
	int z;
	int u;
	int v [N_HID];
	for (int h = 0; h < N_HID; h++) begin
		z = 0;
		for (int i = 0; i < N_IN; i++) begin
			z += int'(x[i]) * int'(w_hid[h][i]);
		end
		v[h] = int'(ref_activation(z));
	end
	for (int o = 0; o < N_OUT; o++) begin
		u = 0;
		for (int h = 0; h < N_HID; h++) begin
			u += v[h] * int'(w_out[o][h]);
		end
		y[o] = nn_types_pkg::out_acc_t'(u);
	end
endfunction

// twice the output minus the desired value
function automatic nn_types_pkg::err_t ref_error(
	input nn_types_pkg::out_acc_t y,
	input nn_types_pkg::in_t      desired
);
	return nn_types_pkg::err_t'(2 * (int'(y) - int'(desired)));
endfunction

`endif

//--- test/tb_bp_nn.sv
// inference pipeline testbench
`timescale 1ns/100ps
`default_nettype none

module tb_bp_nn
	import nn_types_pkg::*, nn_bus_pkg::*;
;

	localparam int N_IN = 4;
	localparam int N_HID = 6;
	localparam int N_OUT = 2;
	localparam int N_W = N_IN * N_HID + N_OUT * N_HID;

	`include "nn_ref_model.svh"

	typedef struct packed {
		out_acc_t [N_OUT-1:0] y;
		err_t     [N_OUT-1:0] err;
		logic     [31:0]      due;
	} expect_t;

	logic        clk;
	logic        reset;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	logic        sample_valid;
	in_t         sample_x [N_IN];
	in_t         sample_desired [N_OUT];
	logic        result_valid;
	out_acc_t    result_y [N_OUT];
	err_t        result_err [N_OUT];

	// own copy of the weights kept in step with every bus write
	weight_t     m_hid [N_HID][N_IN];
	weight_t     m_out [N_OUT][N_HID];
	expect_t     exp_q [$];
	int          seed = 23;
	int          cycle_count = 0;
	int          tests = 0;
	int          errors = 0;
	int          test_errors = 0;
	string       test_name = "startup";
	logic [15:0] rd;

	bp_nn_top i_bp_nn_top (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	function automatic int rand_between(input int lo, input int hi);
		return lo + int'({$random(seed)} % (hi - lo + 1));
	endfunction

	// magnitude in lo..hi with a random sign
	function automatic int rand_signed(input int lo, input int hi);
		int m;
		m = rand_between(lo, hi);
		return (rand_between(0, 1) == 1) ? m : -m;
	endfunction

	// expected read data by the address map
	function automatic logic [15:0] model_read(input int adr);
		weight_t w;
		w = '0;
		if (adr < N_IN * N_HID) begin
			w = m_hid[adr / N_IN][adr % N_IN];
		end else if (adr < N_W) begin
			w = m_out[(adr - N_IN * N_HID) / N_HID][(adr - N_IN * N_HID) % N_HID];
		end
		return 16'(int'(w));
	endfunction

	task automatic report_mismatch(input string what, input longint expected,
			input longint actual);
		errors++;
		$display("FAILED %s %s expected %0d actual %0d", test_name, what, expected, actual);
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("%s: %s", test_name, msg);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = errors;
	endtask

	task automatic finish_test();
		tests++;
		$display("%s: %0d errors", test_name, errors - test_errors);
	endtask

	// one classic cycle with the request held until ack
	task automatic wb_access(input logic we, input int adr, input logic [15:0] dat,
			output logic [15:0] rdata);
		int waited;
		@(posedge clk);
		#2;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: WB_ADR_W'(adr), dat: dat};
		waited = 0;
		do begin
			@(posedge clk);
			#2;
			waited++;
		end while (!wb_rsp.ack && waited < 20);
		if (!wb_rsp.ack) begin
			note_failure($sformatf("no ack from the weight store at address %0d", adr));
		end
		rdata = wb_rsp.dat;
		wb_req = '0;
	endtask

	task automatic wb_write(input int adr, input logic [15:0] dat);
		logic [15:0] ignored;
		wb_access(1'b1, adr, dat, ignored);
		// the store keeps the low byte only
		if (adr < N_IN * N_HID) begin
			m_hid[adr / N_IN][adr % N_IN] = weight_t'(dat[7:0]);
		end else if (adr < N_W) begin
			m_out[(adr - N_IN * N_HID) / N_HID][(adr - N_IN * N_HID) % N_HID] =
				weight_t'(dat[7:0]);
		end
	endtask

	task automatic wb_read(input int adr, output logic [15:0] rdata);
		wb_access(1'b0, adr, 16'h0000, rdata);
	endtask

	// one sample on the next cycle with its expected result queued
	task automatic drive_sample(input int lo, input int hi);
		out_acc_t y [N_OUT];
		expect_t  e;
		@(posedge clk);
		#2;
		for (int i = 0; i < N_IN; i++) begin
			sample_x[i] = in_t'(rand_signed(lo, hi));
		end
		for (int o = 0; o < N_OUT; o++) begin
			sample_desired[o] = in_t'(rand_between(-255, 255));
		end
		sample_valid = 1'b1;
		ref_forward(sample_x, m_hid, m_out, y);
		for (int o = 0; o < N_OUT; o++) begin
			e.y[o] = y[o];
			e.err[o] = ref_error(y[o], sample_desired[o]);
		end
		// result due three edges from now
		e.due = cycle_count + 3;
		exp_q.push_back(e);
	endtask

	task automatic wait_results();
		int waited;
		@(posedge clk);
		#2;
		sample_valid = 1'b0;
		waited = 0;
		while (exp_q.size() > 0 && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		if (exp_q.size() > 0) begin
			note_failure("results still missing after the last sample");
		end
	endtask

	// compare process on the falling edge
	always @(negedge clk) begin
		expect_t e;
		if (result_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				note_failure("result_valid high with no sample in flight");
			end else begin
				e = exp_q.pop_front();
				if (cycle_count != e.due) begin
					report_mismatch("result cycle", e.due, cycle_count);
				end
				for (int o = 0; o < N_OUT; o++) begin
					if (result_y[o] !== e.y[o]) begin
						report_mismatch($sformatf("result_y[%0d]", o), $signed(e.y[o]),
							result_y[o]);
					end
					if (result_err[o] !== e.err[o]) begin
						report_mismatch($sformatf("result_err[%0d]", o), $signed(e.err[o]),
							result_err[o]);
					end
				end
			end
		end else if (exp_q.size() > 0 && exp_q[0].due <= cycle_count) begin
			note_failure("no result in the cycle it was due");
			void'(exp_q.pop_front());
		end
	end

	initial begin
		wb_req = '0;
		sample_valid = 1'b0;
		sample_x = '{default: '0};
		sample_desired = '{default: '0};
		m_hid = '{default: '0};
		m_out = '{default: '0};
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;

		start_test("reset_state");
		@(negedge clk);
		if (result_valid !== 1'b0) begin
			report_mismatch("result_valid", 0, result_valid);
		end
		if (wb_rsp.ack !== 1'b0) begin
			report_mismatch("wb_rsp.ack", 0, wb_rsp.ack);
		end
		for (int a = 0; a < N_W; a++) begin
			wb_read(a, rd);
			if (rd !== 16'h0000) begin
				report_mismatch($sformatf("read of address %0d", a), 0, rd);
			end
		end
		finish_test();

		start_test("weight_readback");
		for (int a = 0; a < N_W; a++) begin
			wb_write(a, 16'($random(seed)));
		end
		for (int a = 0; a < N_W; a++) begin
			wb_read(a, rd);
			if (rd !== model_read(a)) begin
				report_mismatch($sformatf("read of address %0d", a), model_read(a), rd);
			end
		end
		wb_write(255, 16'h5a5a);
		wb_read(255, rd);
		if (rd !== 16'h0000) begin
			report_mismatch("read of unmapped address 255", 0, rd);
		end
		finish_test();

		start_test("single_small_sample");
		drive_sample(0, 5);
		wait_results();
		finish_test();

		start_test("saturated_activation");
		for (int a = 0; a < N_IN * N_HID; a++) begin
			wb_write(a, 16'(rand_signed(100, 127)));
		end
		for (int a = N_IN * N_HID; a < N_W; a++) begin
			wb_write(a, 16'(rand_signed(0, 127)));
		end
		for (int n = 0; n < 4; n++) begin
			drive_sample(200, 255);
		end
		wait_results();
		finish_test();

		start_test("back_to_back_samples");
		for (int a = 0; a < N_W; a++) begin
			wb_write(a, 16'($random(seed)));
		end
		for (int n = 0; n < 20; n++) begin
			drive_sample(0, 255);
		end
		wait_results();
		finish_test();

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
src/nn_types_pkg.sv
src/nn_bus_pkg.sv
src/weight_store.sv
src/hidden_layer.sv
src/activation_stage.sv
src/output_layer.sv
src/bp_nn_top.sv
test/tb_bp_nn.sv
